//--- battleship.f
+incdir+.
battleship_pkg.sv
game_fsm.sv
cursor_ctrl.sv
pc_placer.sv
board_store.sv
seg7_status.sv
battleship.sv
tb_battleship.sv

//--- Makefile
SIM      := verilator
TOP      := tb_battleship
FILELIST := battleship.f
FLAGS    := --binary --timing --assert -Wno-fatal
LINT     := --lint-only --timing -Wall
OBJ_DIR  := obj_dir
SOURCES  := $(shell grep -v '^+' $(FILELIST)) battleship_config.svh

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_battleship.sv
`timescale 1ns/100ps
`include "battleship_config.svh"

module tb_battleship;

	localparam int CYCLE_LIMIT = 4000; // Resets, placement, setup and a double sweep, with margin

	logic                        clk;
	logic                        i_arst_n;
	logic [2:0]                  i_ship_amount;
	logic                        i_confirm_amount;
	logic                        i_move_up;
	logic                        i_move_down;
	logic                        i_move_left;
	logic                        i_move_right;
	logic                        i_place;
	logic                        i_fire;
	battleship_pkg::game_state_t o_state;
	logic                        o_placement_error;
	logic                        o_shot_hit;
	logic                        o_shot_miss;
	logic [6:0]                  o_seg_amount;
	logic [6:0]                  o_seg_player_left;
	logic [6:0]                  o_seg_pc_left;

	string       test_name;
	int          err_cnt;
	int          test_err_base; // Errors before the running test
	int          tests_run;
	int          tests_failed;
	int          cycle_cnt;
	logic [31:0] lfsr;
	int          exp_amount;       // Expected at the next rising edge
	int          exp_player_left;
	int          exp_pc_left;
	int          pend_amount;      // Takes effect one edge later
	int          pend_player_left;
	logic        exp_err;
	logic        pend_err;
	logic        exp_shot;         // Exactly one hit or miss pulse due
	logic        pend_shot;
	logic        pc_known;         // Low while the computer places
	logic        play_model;
	logic        move_model;       // Cursor moves in PLACE and PLAY
	logic        exp_victory;
	logic        end_chk;
	int          hits_seen;
	int          cur_row;
	int          cur_col;
	logic        occupied [`BOARD_N][`BOARD_N]; // Player board
	logic        fired    [`BOARD_N][`BOARD_N]; // Cells already shot at

	battleship u_battleship (
		.clk               (clk),
		.i_arst_n          (i_arst_n),
		.i_ship_amount     (i_ship_amount),
		.i_confirm_amount  (i_confirm_amount),
		.i_move_up         (i_move_up),
		.i_move_down       (i_move_down),
		.i_move_left       (i_move_left),
		.i_move_right      (i_move_right),
		.i_place           (i_place),
		.i_fire            (i_fire),
		.o_state           (o_state),
		.o_placement_error (o_placement_error),
		.o_shot_hit        (o_shot_hit),
		.o_shot_miss       (o_shot_miss),
		.o_seg_amount      (o_seg_amount),
		.o_seg_player_left (o_seg_player_left),
		.o_seg_pc_left     (o_seg_pc_left)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the game did not finish within %0d cycles", CYCLE_LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// Segments a..g on bits 0..6, written as gfedcba
	function automatic logic [6:0] digit_segments(input int d);
		case (d)
			0:       return 7'b0111111;
			1:       return 7'b0000110;
			2:       return 7'b1011011;
			3:       return 7'b1001111;
			4:       return 7'b1100110;
			5:       return 7'b1101101;
			6:       return 7'b1111101;
			default: return 7'b0000111;
		endcase
	endfunction

	// Galois form, taps of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int val);
		int i;
		val = 0;
		for (i = 0; i < n; i++) begin
			val = (val << 1) | int'(lfsr[0]);
			lfsr = lfsr_step(lfsr); // One step per bit
		end
	endtask

	task automatic report_value(input string what, input int expected, input int actual);
		err_cnt++;
		$display("ERROR %s: %s expected 'h%0h, actual 'h%0h", test_name, what, expected, actual);
	endtask

	task automatic start_test(input string name);
		test_name     = name;
		test_err_base = err_cnt;
	endtask

	task automatic close_test();
		tests_run++;
		if (err_cnt == test_err_base) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, err_cnt - test_err_base);
		end
	endtask

	// Next falling edge, strobes drop and pending results become due
	task automatic tick();
		@(negedge clk);
		i_confirm_amount = 1'b0;
		i_move_up        = 1'b0;
		i_move_down      = 1'b0;
		i_move_left      = 1'b0;
		i_move_right     = 1'b0;
		i_place          = 1'b0;
		i_fire           = 1'b0;
		if (play_model && exp_pc_left == 0) exp_victory = 1'b1; // One cycle after the last hit
		if (play_model && o_shot_hit) begin
			exp_pc_left--;
			hits_seen++;
		end
		exp_amount      = pend_amount;
		exp_player_left = pend_player_left;
		exp_err         = pend_err;
		exp_shot        = pend_shot;
		pend_err        = 1'b0;
		pend_shot       = 1'b0;
	endtask

	task automatic apply_reset();
		i_arst_n         = 1'b0;
		i_ship_amount    = 3'd0;
		pend_amount      = 0;
		pend_player_left = 0;
		pend_err         = 1'b0;
		pend_shot        = 1'b0;
		exp_pc_left      = 0;
		pc_known         = 1'b1; // Zero until setup
		play_model       = 1'b0;
		move_model       = 1'b0;
		exp_victory      = 1'b0;
		end_chk          = 1'b0;
		hits_seen        = 0;
		cur_row          = 0;
		cur_col          = 0;
		foreach (occupied[r, c]) begin
			occupied[r][c] = 1'b0;
			fired[r][c]    = 1'b0;
		end
		repeat (5) tick();
		i_arst_n = 1'b1;
	endtask

	task automatic confirm_amount(input logic [2:0] req);
		int clamped;
		if (req == 3'd0) clamped = 1;
		else if (int'(req) > `MAX_SHIPS) clamped = `MAX_SHIPS;
		else clamped = int'(req);
		tick();
		i_ship_amount    = req;
		i_confirm_amount = 1'b1;
		pend_amount      = clamped;
		pend_player_left = clamped; // PLACE starts with the whole fleet
		move_model       = 1'b1;
		tick();
	endtask

	// 0 up, 1 down, 2 left, 3 right
	task automatic move_cursor(input int dir);
		logic live;
		tick();
		live = move_model && !exp_victory;
		case (dir)
			0: begin
				i_move_up = 1'b1;
				if (live) cur_row = (cur_row == 0) ? `BOARD_N - 1 : cur_row - 1;
			end
			1: begin
				i_move_down = 1'b1;
				if (live) cur_row = (cur_row == `BOARD_N - 1) ? 0 : cur_row + 1;
			end
			2: begin
				i_move_left = 1'b1;
				if (live) cur_col = (cur_col == 0) ? `BOARD_N - 1 : cur_col - 1;
			end
			default: begin
				i_move_right = 1'b1;
				if (live) cur_col = (cur_col == `BOARD_N - 1) ? 0 : cur_col + 1;
			end
		endcase
	endtask

	task automatic place_ship();
		tick();
		i_place = 1'b1;
		if (pend_player_left > 0) begin
			if (occupied[cur_row][cur_col]) begin
				pend_err = 1'b1; // Repeated cell
			end else begin
				occupied[cur_row][cur_col] = 1'b1;
				pend_player_left--;
			end
		end
	endtask

	task automatic fire_shot();
		tick();
		i_fire = 1'b1;
		if (play_model && !exp_victory && !fired[cur_row][cur_col]) begin
			pend_shot                  = 1'b1; // First shot resolves the cell
			fired[cur_row][cur_col]    = 1'b1;
		end
	endtask

	a_amount: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_seg_amount == digit_segments(exp_amount))
		else report_value("amount digit", digit_segments(exp_amount), int'($sampled(o_seg_amount)));

	a_player_left: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_seg_player_left == digit_segments(exp_player_left))
		else report_value("player_left digit", digit_segments(exp_player_left),
			int'($sampled(o_seg_player_left)));

	a_pc_left: assert property (@(posedge clk) disable iff (!i_arst_n)
		pc_known |-> o_seg_pc_left == digit_segments(exp_pc_left))
		else report_value("pc_left digit", digit_segments(exp_pc_left),
			int'($sampled(o_seg_pc_left)));

	a_place_error: assert property (@(posedge clk) disable iff (!i_arst_n)
		o_placement_error == exp_err)
		else report_value("placement error", int'(exp_err), int'($sampled(o_placement_error)));

	// A fresh cell answers with one pulse, anything else stays quiet
	a_shot_one: assert property (@(posedge clk) disable iff (!i_arst_n)
		exp_shot |-> (o_shot_hit != o_shot_miss))
		else report_value("shot pulses", 1, int'($sampled(o_shot_hit)) + int'($sampled(o_shot_miss)));

	a_shot_quiet: assert property (@(posedge clk) disable iff (!i_arst_n)
		!exp_shot |-> !(o_shot_hit || o_shot_miss))
		else report_value("shot pulses", 0, int'($sampled(o_shot_hit)) + int'($sampled(o_shot_miss)));

	a_victory_time: assert property (@(posedge clk) disable iff (!i_arst_n)
		play_model |-> ((o_state == battleship_pkg::VICTORY) == exp_victory))
		else report_value("victory state", int'(exp_victory),
			int'($sampled(o_state) == battleship_pkg::VICTORY));

	a_hit_total: assert property (@(posedge clk) disable iff (!i_arst_n)
		end_chk |-> hits_seen == exp_amount)
		else report_value("hit count", exp_amount, hits_seen);

	a_game_won: assert property (@(posedge clk) disable iff (!i_arst_n)
		end_chk |-> o_state == battleship_pkg::VICTORY)
		else report_value("final state", int'(battleship_pkg::VICTORY), int'($sampled(o_state)));

	initial begin
		int req;
		int steps;
		int dir;
		int left_before;
		int r;
		int c;
		int k;
		lfsr             = 32'hba7e90d1;
		i_arst_n         = 1'b0;
		i_ship_amount    = 3'd0;
		i_confirm_amount = 1'b0;
		i_move_up        = 1'b0;
		i_move_down      = 1'b0;
		i_move_left      = 1'b0;
		i_move_right     = 1'b0;
		i_place          = 1'b0;
		i_fire           = 1'b0;
		err_cnt          = 0;
		tests_run        = 0;
		tests_failed     = 0;
		cycle_cnt        = 0;
		exp_amount       = 0;
		exp_player_left  = 0;
		exp_err          = 1'b0;
		exp_shot         = 1'b0;

		start_test("clamp_zero");
		apply_reset();
		confirm_amount(3'd0);
		tick();
		close_test();

		start_test("clamp_seven");
		apply_reset();
		confirm_amount(3'd7);
		tick();
		close_test();

		start_test("placement");
		apply_reset();
		take_bits(3, req);
		confirm_amount(3'(req));
		while (pend_player_left > 0) begin
			take_bits(2, steps);
			for (k = 0; k < steps; k++) begin
				take_bits(2, dir);
				move_cursor(dir);
			end
			left_before = pend_player_left;
			place_ship();
			// Same cell again must be refused
			if (pend_player_left != left_before && pend_player_left > 0) place_ship();
		end
		tick();
		pc_known   = 1'b0; // Computer fleet grows from here
		move_model = 1'b0;
		close_test();

		start_test("setup");
		while (o_state != battleship_pkg::PLAY) tick();
		exp_pc_left = exp_amount; // Full fleet afloat
		pc_known    = 1'b1;
		play_model  = 1'b1;
		move_model  = 1'b1;
		tick();
		close_test();

		start_test("attack");
		while (cur_row != 0) move_cursor(0);
		while (cur_col != 0) move_cursor(2);
		for (r = 0; r < `BOARD_N; r++) begin
			for (c = 0; c < `BOARD_N; c++) begin
				if (!exp_victory) begin
					fire_shot();
					fire_shot(); // Resolved cell, no pulse
					move_cursor(3);
				end
			end
			if (!exp_victory) move_cursor(1);
		end
		tick();
		tick();
		close_test();

		start_test("victory");
		end_chk = 1'b1;
		tick();
		end_chk = 1'b0;
		fire_shot();
		tick();
		tick();
		close_test();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0 && tests_failed == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- battleship.sv
`timescale 1ns/100ps

module battleship (
	input  logic                        clk,
	input  logic                        i_arst_n,
	input  logic [2:0]                  i_ship_amount,
	input  logic                        i_confirm_amount,
	input  logic                        i_move_up,
	input  logic                        i_move_down,
	input  logic                        i_move_left,
	input  logic                        i_move_right,
	input  logic                        i_place,
	input  logic                        i_fire,
	output battleship_pkg::game_state_t o_state,
	output logic                        o_placement_error,
	output logic                        o_shot_hit,
	output logic                        o_shot_miss,
	output logic [6:0]                  o_seg_amount,
	output logic [6:0]                  o_seg_player_left,
	output logic [6:0]                  o_seg_pc_left
);

	battleship_pkg::game_state_t state;     // Phase seen by every block
	logic [2:0]                  amount;
	battleship_pkg::coord_t      cursor;
	battleship_pkg::coord_t      candidate; // Computer placement proposal
	battleship_pkg::counts_t     counts;
	logic                        player_done;
	logic                        pc_setup_full;
	logic                        pc_done;

	game_fsm u_game_fsm (
		.clk              (clk),
		.i_arst_n         (i_arst_n),
		.i_ship_amount    (i_ship_amount),
		.i_confirm_amount (i_confirm_amount),
		.i_player_done    (player_done),
		.i_pc_setup_full  (pc_setup_full),
		.i_pc_done        (pc_done),
		.o_state          (state),
		.o_amount         (amount)
	);

	cursor_ctrl u_cursor_ctrl (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_state      (state),
		.i_move_up    (i_move_up),
		.i_move_down  (i_move_down),
		.i_move_left  (i_move_left),
		.i_move_right (i_move_right),
		.o_cursor     (cursor)
	);

	pc_placer u_pc_placer (
		.clk         (clk),
		.i_arst_n    (i_arst_n),
		.i_state     (state),
		.o_candidate (candidate)
	);

	board_store u_board_store (
		.clk               (clk),
		.i_arst_n          (i_arst_n),
		.i_state           (state),
		.i_amount          (amount),
		.i_cursor          (cursor),
		.i_candidate       (candidate),
		.i_place           (i_place),
		.i_fire            (i_fire),
		.o_counts          (counts),
		.o_player_done     (player_done),
		.o_pc_setup_full   (pc_setup_full),
		.o_pc_done         (pc_done),
		.o_placement_error (o_placement_error),
		.o_shot_hit        (o_shot_hit),
		.o_shot_miss       (o_shot_miss)
	);

	seg7_status u_seg7_status (
		.i_counts          (counts),
		.o_seg_amount      (o_seg_amount),
		.o_seg_player_left (o_seg_player_left),
		.o_seg_pc_left     (o_seg_pc_left)
	);

	assign o_state = state;

endmodule

//--- seg7_status.sv
`timescale 1ns/100ps

module seg7_status (
	input  battleship_pkg::counts_t i_counts,
	output logic [6:0]              o_seg_amount,      // Ships per side
	output logic [6:0]              o_seg_player_left, // Player ships still to place
	output logic [6:0]              o_seg_pc_left      // Computer ships afloat
);

	// Bit 0 is segment a, bit 6 is segment g, lit when high
	function automatic logic [6:0] seg_decode(input logic [2:0] digit);
		logic [6:0] seg;
		case (digit)
			3'd0:    seg = 7'h3f;
			3'd1:    seg = 7'h06; // b c
			3'd2:    seg = 7'h5b;
			3'd3:    seg = 7'h4f;
			3'd4:    seg = 7'h66;
			3'd5:    seg = 7'h6d;
			3'd6:    seg = 7'h7d;
			default: seg = 7'h07; // Seven, a b c
		endcase
		return seg;
	endfunction

	// Three displays share one decoder
	assign o_seg_amount      = seg_decode(i_counts.amount);
	assign o_seg_player_left = seg_decode(i_counts.player_left);
	assign o_seg_pc_left     = seg_decode(i_counts.pc_left);

endmodule

//--- board_store.sv
`timescale 1ns/100ps
`include "battleship_config.svh"

module board_store (
	input  logic                        clk,
	input  logic                        i_arst_n,
	input  battleship_pkg::game_state_t i_state,
	input  logic [2:0]                  i_amount,
	input  battleship_pkg::coord_t      i_cursor,    // Player cursor, used to place and to fire
	input  battleship_pkg::coord_t      i_candidate, // Computer placement proposal
	input  logic                        i_place,     // Placement strobe
	input  logic                        i_fire,      // Attack strobe
	output battleship_pkg::counts_t     o_counts,
	output logic                        o_player_done,
	output logic                        o_pc_setup_full,
	output logic                        o_pc_done,
	output logic                        o_placement_error,
	output logic                        o_shot_hit,
	output logic                        o_shot_miss
);

	battleship_pkg::cell_t player_board [`BOARD_N][`BOARD_N]; // Player fleet
	battleship_pkg::cell_t pc_board     [`BOARD_N][`BOARD_N]; // Computer fleet, shot at

	logic [2:0]            player_placed; // Ships the player has put down
	logic [2:0]            player_left;
	logic [2:0]            pc_left;       // Grows in SETUP, shrinks in PLAY
	battleship_pkg::cell_t cursor_cell;   // Player board under the cursor
	battleship_pkg::cell_t target_cell;   // Computer board under the cursor
	battleship_pkg::cell_t cand_cell;     // Computer board under the candidate
	logic                  do_place;
	logic                  place_ok;
	logic                  do_pc_place;
	logic                  do_fire;

	assign cursor_cell = player_board[i_cursor.row][i_cursor.col];
	assign target_cell = pc_board[i_cursor.row][i_cursor.col];
	assign cand_cell   = pc_board[i_candidate.row][i_candidate.col];

	// Remaining placements follow the amount, so PLACE starts full
	assign player_left = i_amount - player_placed;

	// Strobes only count in their own phase
	assign do_place    = (i_state == battleship_pkg::PLACE) && i_place && (player_left != 3'd0);
	assign place_ok    = do_place && (cursor_cell == battleship_pkg::CELL_EMPTY);
	assign do_pc_place = (i_state == battleship_pkg::SETUP) && !o_pc_setup_full &&
	                     (cand_cell == battleship_pkg::CELL_EMPTY); // Occupied candidates are skipped
	assign do_fire     = (i_state == battleship_pkg::PLAY) && i_fire;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int r = 0; r < `BOARD_N; r++) begin
				for (int c = 0; c < `BOARD_N; c++) begin
					player_board[r][c] <= battleship_pkg::CELL_EMPTY;
					pc_board[r][c]     <= battleship_pkg::CELL_EMPTY;
				end
			end
		end else begin
			if (place_ok) player_board[i_cursor.row][i_cursor.col] <= battleship_pkg::CELL_SHIP;
			if (do_pc_place) pc_board[i_candidate.row][i_candidate.col] <= battleship_pkg::CELL_SHIP;
			if (do_fire) begin
				case (target_cell)
					battleship_pkg::CELL_SHIP: begin
						pc_board[i_cursor.row][i_cursor.col] <= battleship_pkg::CELL_HIT;
					end
					battleship_pkg::CELL_EMPTY: begin
						pc_board[i_cursor.row][i_cursor.col] <= battleship_pkg::CELL_MISS;
					end
					default: ; // Already resolved, left as is
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			player_placed     <= 3'd0;
			pc_left           <= 3'd0;
			o_placement_error <= 1'b0;
			o_shot_hit        <= 1'b0;
			o_shot_miss       <= 1'b0;
		end else begin
			// One-cycle result pulses
			o_placement_error <= do_place && !place_ok;
			o_shot_hit        <= do_fire && (target_cell == battleship_pkg::CELL_SHIP);
			o_shot_miss       <= do_fire && (target_cell == battleship_pkg::CELL_EMPTY);
			if (place_ok) player_placed <= player_placed + 3'd1;
			if (do_pc_place) begin
				pc_left <= pc_left + 3'd1;
			end else if (do_fire && target_cell == battleship_pkg::CELL_SHIP) begin
				pc_left <= pc_left - 3'd1; // Sunk one
			end
		end
	end

	assign o_counts.amount      = i_amount;
	assign o_counts.player_left = player_left;
	assign o_counts.pc_left     = pc_left;

	assign o_player_done   = (i_state == battleship_pkg::PLACE) && (player_left == 3'd0);
	assign o_pc_setup_full = (pc_left == i_amount);
	assign o_pc_done       = (i_state == battleship_pkg::PLAY) && (pc_left == 3'd0);

	// Computer fleet never outgrows the amount chosen by the FSM
	a_pc_left_bound: assert property (@(posedge clk) disable iff (!i_arst_n)
		pc_left <= i_amount)
		else $error("board_store: pc_left %0d above amount %0d", pc_left, i_amount);

endmodule

//--- pc_placer.sv
`timescale 1ns/100ps
`include "battleship_config.svh"

module pc_placer (
	input  logic                        clk,
	input  logic                        i_arst_n,
	input  battleship_pkg::game_state_t i_state,
	output battleship_pkg::coord_t      o_candidate // Next cell the computer tries
);

	// x^16 + x^14 + x^13 + x^11 + 1, right shifting form
	localparam logic [15:0] TAPS = 16'hb400;

	logic [15:0] lfsr_q;
	logic [15:0] lfsr_d;

	// Four random bits folded onto 0..BOARD_N-1
	function automatic logic [`COORD_W-1:0] mod_board(input logic [3:0] bits);
		logic [3:0] rem;
		rem = bits % 4'(`BOARD_N);
		return rem[`COORD_W-1:0];
	endfunction

	// Galois step, feedback from the bit that falls out
	assign lfsr_d = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? TAPS : 16'h0000);

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			lfsr_q <= `PC_LFSR_SEED;
		end else if (i_state == battleship_pkg::SETUP) begin
			lfsr_q <= lfsr_d; // Free run only while the computer places
		end
	end

	// Row and column from separate nibbles
	assign o_candidate.row = mod_board(lfsr_q[3:0]);
	assign o_candidate.col = mod_board(lfsr_q[11:8]);

	// All-zero state would lock the generator
	a_lfsr_alive: assert property (@(posedge clk) disable iff (!i_arst_n)
		lfsr_q != 16'h0000)
		else $error("pc_placer: LFSR stuck at zero");

endmodule

//--- cursor_ctrl.sv
`timescale 1ns/100ps
`include "battleship_config.svh"

module cursor_ctrl (
	input  logic                        clk,
	input  logic                        i_arst_n,
	input  battleship_pkg::game_state_t i_state,
	input  logic                        i_move_up,    // Row minus one
	input  logic                        i_move_down,  // Row plus one
	input  logic                        i_move_left,  // Column minus one
	input  logic                        i_move_right, // Column plus one
	output battleship_pkg::coord_t      o_cursor
);

	localparam int LAST = `BOARD_N - 1;
	localparam logic [`COORD_W-1:0] LAST_IDX = LAST[`COORD_W-1:0]; // Bottom row, right column

	battleship_pkg::coord_t cursor_q;
	battleship_pkg::coord_t cursor_d;
	logic                   move_en; // Cursor only moves while the player acts

	assign move_en = (i_state == battleship_pkg::PLACE) || (i_state == battleship_pkg::PLAY);

	always_comb begin
		cursor_d = cursor_q;
		if (move_en) begin
			// Up wins over down if both arrive together
			if (i_move_up) begin
				cursor_d.row = (cursor_q.row == '0) ? LAST_IDX : cursor_q.row - 1'b1;
			end else if (i_move_down) begin
				cursor_d.row = (cursor_q.row == LAST_IDX) ? '0 : cursor_q.row + 1'b1;
			end
			if (i_move_left) begin
				cursor_d.col = (cursor_q.col == '0) ? LAST_IDX : cursor_q.col - 1'b1;
			end else if (i_move_right) begin
				cursor_d.col = (cursor_q.col == LAST_IDX) ? '0 : cursor_q.col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) cursor_q <= '0; // Top left corner
		else           cursor_q <= cursor_d;
	end

	assign o_cursor = cursor_q;

	// Wrap logic must keep the cursor on the board
	a_cursor_on_board: assert property (@(posedge clk) disable iff (!i_arst_n)
		(cursor_q.row < 3'(`BOARD_N)) && (cursor_q.col < 3'(`BOARD_N)))
		else $error("cursor_ctrl: cursor left the board");

endmodule

//--- game_fsm.sv
`timescale 1ns/100ps
`include "battleship_config.svh"

module game_fsm (
	input  logic                        clk,
	input  logic                        i_arst_n,
	input  logic [2:0]                  i_ship_amount,    // Raw request from the switches
	input  logic                        i_confirm_amount, // Strobe, only seen in DECIDE
	input  logic                        i_player_done,    // All player ships placed
	input  logic                        i_pc_setup_full,  // Computer fleet complete
	input  logic                        i_pc_done,        // Every computer ship hit
	output battleship_pkg::game_state_t o_state,
	output logic [2:0]                  o_amount
);

	battleship_pkg::game_state_t state_q; // Current phase
	battleship_pkg::game_state_t state_d; // Phase for the next edge
	logic [2:0]                  amount_clamped;
	logic [2:0]                  amount_q; // Amount locked in at confirmation

	// Keep the request inside 1..MAX_SHIPS
	always_comb begin
		if (i_ship_amount == 3'd0) begin
			amount_clamped = 3'd1; // Zero ships makes no game
		end else if (i_ship_amount > 3'(`MAX_SHIPS)) begin
			amount_clamped = 3'(`MAX_SHIPS);
		end else begin
			amount_clamped = i_ship_amount;
		end
	end

	always_comb begin
		state_d = state_q; // Hold by default
		case (state_q)
			battleship_pkg::DECIDE: begin
				if (i_confirm_amount) state_d = battleship_pkg::PLACE;
			end
			battleship_pkg::PLACE: begin
				if (i_player_done) state_d = battleship_pkg::SETUP;
			end
			battleship_pkg::SETUP: begin
				if (i_pc_setup_full) state_d = battleship_pkg::PLAY;
			end
			battleship_pkg::PLAY: begin
				if (i_pc_done) state_d = battleship_pkg::VICTORY;
			end
			default: state_d = state_q; // VICTORY is final until reset
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q  <= battleship_pkg::DECIDE;
			amount_q <= 3'd0;
		end else begin
			state_q <= state_d;
			// Amount is captured on the same edge that leaves DECIDE
			if (state_q == battleship_pkg::DECIDE && i_confirm_amount) begin
				amount_q <= amount_clamped;
			end
		end
	end

	assign o_state  = state_q;
	assign o_amount = amount_q;

	// Once the game has started the amount must be a legal fleet size
	a_amount_legal: assert property (@(posedge clk) disable iff (!i_arst_n)
		(state_q != battleship_pkg::DECIDE) |->
			(amount_q >= 3'd1 && amount_q <= 3'(`MAX_SHIPS)))
		else $error("game_fsm: amount %0d out of range", amount_q);

endmodule

//--- battleship_pkg.sv
`include "battleship_config.svh"

package battleship_pkg;

	// State of one board cell
	typedef enum logic [1:0] {
		CELL_EMPTY = 2'd0, // Water, never shot
		CELL_SHIP  = 2'd1, // Ship, not hit yet
		CELL_HIT   = 2'd2, // Ship that was shot
		CELL_MISS  = 2'd3  // Water that was shot
	} cell_t;

	// Board position, row 0 is the top line
	typedef struct packed {
		logic [`COORD_W-1:0] row;
		logic [`COORD_W-1:0] col;
	} coord_t;

	// Game phases in the order they are visited
	typedef enum logic [2:0] {
		DECIDE  = 3'd0, // Player picks the ship amount
		PLACE   = 3'd1, // Player places own ships
		SETUP   = 3'd2, // Computer places its ships
		PLAY    = 3'd3, // Player fires at the computer board
		VICTORY = 3'd4  // All computer ships sunk
	} game_state_t;

	// Ship counters shown on the displays
	typedef struct packed {
		logic [2:0] amount;      // Ships per side for this game
		logic [2:0] player_left; // Player ships still to place
		logic [2:0] pc_left;     // Computer ships still afloat
	} counts_t;

endpackage

//--- battleship_config.svh
`ifndef BATTLESHIP_CONFIG_SVH
`define BATTLESHIP_CONFIG_SVH

// Board geometry

// Cells per side, the board is square
`define BOARD_N 5

// Ship limits

// Largest amount of single-cell ships per player
`define MAX_SHIPS 5

// Coordinate encoding

// Bits per row or column field, wide enough for BOARD_N - 1
`define COORD_W 3

// Computer placement

// Start value of the placer LFSR, must not be zero
`define PC_LFSR_SEED 16'hace1

`endif
